// File: include/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Cache and memory geometry
`define DC_ADDR_W  10     // Word address
`define DC_DATA_W  32
`define DC_SETS    32
`define DC_INDEX_W 5
`define DC_TAG_W   5      // ADDR_W - INDEX_W
`define DC_BYTES   4      // Byte lanes per word

`endif

// File: src/dcache_pkg.sv
`default_nettype none
`include "dcache_cfg.svh"

package dcache_pkg;

    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } cache_op_e;

    // Per-cycle decision of the cache
    typedef enum logic [1:0] {
        ACT_NONE  = 2'd0,
        ACT_HIT   = 2'd1,
        ACT_FILL  = 2'd2,
        ACT_EVICT = 2'd3
    } line_action_e;

    typedef struct packed {
        cache_op_e               op;
        logic [`DC_ADDR_W-1:0]   address;     // Tag high, index low
        logic [`DC_DATA_W-1:0]   write_data;
        logic [`DC_BYTES-1:0]    write_mask;  // Bit i enables byte i
    } cache_req_t;

    typedef struct packed {
        logic [`DC_ADDR_W-1:0]   address;
        logic [`DC_DATA_W-1:0]   data;
        logic                    done;        // Active low
    } writeback_t;

endpackage

`default_nettype wire

// File: src/data_memory.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

module data_memory (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`DC_ADDR_W-1:0]  address,
    input  dcache_pkg::writeback_t wb,
    output logic [`DC_DATA_W-1:0]  read_data
);

    localparam int DEPTH = 1 << `DC_ADDR_W;

    logic [`DC_DATA_W-1:0] mem [DEPTH];

    assign read_data = mem[address];    // Refill path, no latency

    // Written only by the cache's one-cycle flush
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (!wb.done) begin
            mem[wb.address] <= wb.data;
        end
    end

endmodule

`default_nettype wire

// File: src/data_cache.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

module data_cache (
    input  logic                   clk,
    input  logic                   reset,
    input  dcache_pkg::cache_req_t req,
    input  logic [`DC_DATA_W-1:0]  mem_data,
    output logic                   hit,
    output logic [`DC_DATA_W-1:0]  read_data,
    output dcache_pkg::writeback_t wb
);
    import dcache_pkg::*;

    localparam int WAYS = 2;
    localparam writeback_t WB_IDLE = '{address: '0, data: '0, done: 1'b1};

    logic [`DC_TAG_W-1:0]   tag_mem  [WAYS][`DC_SETS];
    logic [`DC_DATA_W-1:0]  data_mem [WAYS][`DC_SETS];
    logic [`DC_SETS-1:0]    valid    [WAYS];
    logic [`DC_SETS-1:0]    dirty    [WAYS];
    logic [`DC_SETS-1:0]    lru;               // Way to replace next

    logic [`DC_INDEX_W-1:0] index;
    logic [`DC_TAG_W-1:0]   tag;
    logic                   is_access;
    logic                   is_write;
    logic [WAYS-1:0]        way_hit;
    logic                   hit_way;
    logic                   victim;
    logic                   way_sel;
    logic [`DC_DATA_W-1:0]  line_data;
    logic [`DC_DATA_W-1:0]  merge_base;
    logic [`DC_DATA_W-1:0]  new_data;
    line_action_e           action;

    // Overwrite the enabled byte lanes of base
    function automatic logic [`DC_DATA_W-1:0] merge_bytes(
        input logic [`DC_DATA_W-1:0] base,
        input logic [`DC_DATA_W-1:0] data,
        input logic [`DC_BYTES-1:0]  mask
    );
        logic [`DC_DATA_W-1:0] merged;
        merged = base;
        for (int b = 0; b < `DC_BYTES; b++) begin
            if (mask[b]) begin
                merged[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign index     = req.address[`DC_INDEX_W-1:0];
    assign tag       = req.address[`DC_ADDR_W-1:`DC_INDEX_W];
    assign is_write  = (req.op == OP_WRITE);
    assign is_access = (req.op == OP_READ) || is_write;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = valid[w][index] && (tag_mem[w][index] == tag);
        end
    end

    assign hit     = is_access && (|way_hit);
    assign hit_way = way_hit[1];

    // First invalid way, else the LRU way
    always_comb begin
        if (!valid[0][index]) begin
            victim = 1'b0;
        end else if (!valid[1][index]) begin
            victim = 1'b1;
        end else begin
            victim = lru[index];
        end
    end

    always_comb begin
        if (!is_access) begin
            action = ACT_NONE;
        end else if (|way_hit) begin
            action = ACT_HIT;
        end else if (valid[victim][index] && dirty[victim][index]) begin
            action = ACT_EVICT;
        end else begin
            action = ACT_FILL;
        end
    end

    assign way_sel   = (action == ACT_HIT) ? hit_way : victim;
    assign line_data = data_mem[way_sel][index];

    // Hit writes merge into the line, fills merge into the memory word
    assign merge_base = (action == ACT_HIT) ? line_data : mem_data;
    assign new_data   = is_write ? merge_bytes(merge_base, req.write_data, req.write_mask)
                                 : merge_base;

    always_ff @(posedge clk) begin
        if ((action == ACT_FILL) || (action == ACT_HIT && is_write)) begin
            data_mem[way_sel][index] <= new_data;
        end
        if (action == ACT_FILL) begin
            tag_mem[way_sel][index] <= tag;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid     <= '{default: '0};
            dirty     <= '{default: '0};
            lru       <= '0;
            read_data <= '0;
            wb        <= WB_IDLE;
        end else begin
            read_data <= '0;
            wb        <= WB_IDLE;
            case (action)
                ACT_HIT: begin
                    lru[index] <= ~hit_way;         // Other way becomes LRU
                    if (is_write) begin
                        dirty[hit_way][index] <= 1'b1;
                    end else begin
                        read_data <= line_data;
                    end
                end
                ACT_FILL: begin
                    valid[victim][index] <= 1'b1;
                    dirty[victim][index] <= is_write;
                    lru[index]           <= ~victim;
                end
                ACT_EVICT: begin
                    // Victim stays valid and LRU, refilled next edge
                    wb.address           <= {tag_mem[victim][index], index};
                    wb.data              <= line_data;
                    wb.done              <= 1'b0;
                    dirty[victim][index] <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

module dcache_top (
    input  logic                   clk,
    input  logic                   reset,
    input  dcache_pkg::cache_req_t req,
    output logic                   hit,
    output logic [`DC_DATA_W-1:0]  read_data
);
    import dcache_pkg::*;

    logic [`DC_DATA_W-1:0] mem_data;
    writeback_t            wb;         // Dirty line flush

    data_cache u_cache (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .mem_data  (mem_data),
        .hit       (hit),
        .read_data (read_data),
        .wb        (wb)
    );

    data_memory u_mem (
        .clk       (clk),
        .reset     (reset),
        .address   (req.address),
        .wb        (wb),
        .read_data (mem_data)
    );

endmodule

`default_nettype wire

// File: tests/dcache_assertions.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

module dcache_assertions (
    input logic                     clk,
    input logic                     reset,
    input dcache_pkg::cache_req_t   req,
    input logic                     hit,
    input logic [`DC_DATA_W-1:0]    read_data,
    input dcache_pkg::writeback_t   wb,
    input dcache_pkg::line_action_e action
);
    import dcache_pkg::*;

    logic read_hit;
    int   fail_count = 0;

    assign read_hit = (action == ACT_HIT) && (req.op == OP_READ);

    // Any edge taken in reset leaves the flush idle
    wb_idle_in_reset: assert property (@(posedge clk) reset |=> wb.done)
        else begin
            $error("wb.done low after a reset edge");
            fail_count++;
        end

    wb_single_pulse: assert property (@(posedge clk) disable iff (reset)
        !wb.done |=> wb.done)
        else begin
            $error("wb.done low on two consecutive cycles");
            fail_count++;
        end

    read_data_cleared: assert property (@(posedge clk) disable iff (reset)
        !read_hit |=> (read_data == '0))
        else begin
            $error("read_data nonzero after an edge without a read hit");
            fail_count++;
        end

    wb_needs_request: assert property (@(posedge clk) disable iff (reset)
        (req.op == OP_IDLE) |=> wb.done)
        else begin
            $error("writeback issued after an idle request");
            fail_count++;
        end

endmodule

bind data_cache dcache_assertions u_checks (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .hit       (hit),
    .read_data (read_data),
    .wb        (wb),
    .action    (action)
);

`default_nettype wire

// File: tests/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int DEPTH    = 1 << `DC_ADDR_W;
    localparam int MAX_WAIT = 20;

    logic                  clk;
    logic                  reset;
    cache_req_t            req;
    logic                  hit;
    logic [`DC_DATA_W-1:0] read_data;

    logic [`DC_DATA_W-1:0] model [DEPTH];    // Expected memory image
    logic [31:0]           lcg_state;
    string                 test_name;
    int                    error_count;
    int                    errors_at_start;
    int                    tests_run;
    int                    tests_failed;

    dcache_top uut (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .hit       (hit),
        .read_data (read_data)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Byte lanes under mask take the new word
    function automatic logic [`DC_DATA_W-1:0] masked_update(
        input logic [`DC_DATA_W-1:0] old_word,
        input logic [`DC_DATA_W-1:0] new_word,
        input logic [`DC_BYTES-1:0]  mask
    );
        logic [`DC_DATA_W-1:0] lanes;
        for (int i = 0; i < `DC_BYTES; i++) begin
            lanes[i*8 +: 8] = {8{mask[i]}};
        end
        return (old_word & ~lanes) | (new_word & lanes);
    endfunction

    task automatic check_word(input string what, input logic [`DC_DATA_W-1:0] expected,
                              input logic [`DC_DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s (%s): expected %h, actual %h",
                     test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_hit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s (%s): expected hit %b, actual hit %b",
                     test_name, what, expected, actual);
            error_count++;
        end
    endtask

    // Holds the request until hit, then lets one access edge pass
    task automatic do_access(
        input  cache_op_e               op,
        input  logic [`DC_ADDR_W-1:0]   address,
        input  logic [`DC_DATA_W-1:0]   data,
        input  logic [`DC_BYTES-1:0]    mask,
        output logic [`DC_DATA_W-1:0]   result,
        output logic                    first_hit
    );
        int waits;
        waits  = 0;
        result = '0;
        @(negedge clk);
        req.op         = op;
        req.address    = address;
        req.write_data = data;
        req.write_mask = mask;
        #1;
        first_hit = hit;
        while (!hit && waits < MAX_WAIT) begin
            @(negedge clk);
            #1;
            waits++;
        end
        if (!hit) begin
            $display("%s: no hit within %0d cycles for address %h", test_name, MAX_WAIT,
                     address);
            error_count++;
            @(negedge clk);
        end else begin
            @(posedge clk);
            @(negedge clk);
            result = read_data;
        end
        req.op = OP_IDLE;
        if (op == OP_WRITE) begin
            model[address] = masked_update(model[address], data, mask);
        end
    endtask

    task automatic write_word(input logic [`DC_ADDR_W-1:0] address,
                              input logic [`DC_DATA_W-1:0] data,
                              input logic [`DC_BYTES-1:0]  mask);
        logic [`DC_DATA_W-1:0] unused;
        logic                  first_hit;
        do_access(OP_WRITE, address, data, mask, unused, first_hit);
    endtask

    // expect_first: 0 miss, 1 hit, other values skip the hit check
    task automatic read_compare(input logic [`DC_ADDR_W-1:0] address, input int expect_first);
        logic [`DC_DATA_W-1:0] result;
        logic                  first_hit;
        do_access(OP_READ, address, '0, '0, result, first_hit);
        check_word($sformatf("read %h", address), model[address], result);
        if (expect_first == 0 || expect_first == 1) begin
            check_hit($sformatf("first sample %h", address), expect_first[0], first_hit);
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    task automatic test_reset_state();
        start_test("reset_state");
        @(negedge clk);
        #1;
        check_hit("idle", 1'b0, hit);
        check_word("read_data after reset", '0, read_data);
        read_compare(10'h000, 0);
        read_compare(10'h155, 0);
        read_compare(10'h3ff, 0);
        end_test();
    endtask

    task automatic test_write_read();
        start_test("write_read");
        write_word(10'h041, next_random(), 4'b1111);
        read_compare(10'h041, 1);
        end_test();
    endtask

    task automatic test_partial_masks();
        start_test("partial_masks");
        write_word(10'h0a2, next_random(), 4'b0101);    // Fresh line, fill merge
        read_compare(10'h0a2, 1);
        write_word(10'h0a2, next_random(), 4'b1000);    // Hit merge
        read_compare(10'h0a2, 1);
        write_word(10'h0c3, next_random(), 4'b1111);
        write_word(10'h0c3, next_random(), 4'b0101);
        write_word(10'h0c3, next_random(), 4'b0010);
        read_compare(10'h0c3, 1);
        end_test();
    endtask

    task automatic test_two_ways();
        start_test("two_ways");
        write_word(10'h027, next_random(), 4'b1111);    // Tag 1, index 7
        write_word(10'h1e7, next_random(), 4'b1111);    // Tag 15, index 7
        for (int i = 0; i < 6; i++) begin
            read_compare(i[0] ? 10'h1e7 : 10'h027, 1);
        end
        end_test();
    endtask

    task automatic test_dirty_eviction();
        start_test("dirty_eviction");
        write_word(10'h029, next_random(), 4'b1111);
        write_word(10'h049, next_random(), 4'b1111);
        write_word(10'h069, next_random(), 4'b1111);    // Evicts tag 1
        read_compare(10'h049, 1);
        read_compare(10'h069, 1);
        read_compare(10'h029, 0);                       // Back from memory
        read_compare(10'h049, 0);
        read_compare(10'h069, 0);
        end_test();
    endtask

    task automatic test_random_mix();
        logic [`DC_TAG_W-1:0]   tags [4];
        logic [`DC_INDEX_W-1:0] sets [2];
        logic [31:0]            r;
        logic [`DC_ADDR_W-1:0]  address;
        start_test("random_mix");
        tags[0] = 5'd6;
        tags[1] = 5'd13;
        tags[2] = 5'd22;
        tags[3] = 5'd27;
        sets[0] = 5'd3;
        sets[1] = 5'd20;
        for (int n = 0; n < 60; n++) begin
            r       = next_random();
            address = {tags[r[30:29]], sets[r[28]]};
            if (r[31]) begin
                write_word(address, next_random(), r[19:16]);
            end else begin
                read_compare(address, 2);
            end
        end
        end_test();
    endtask

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        req             = '0;
        req.op          = OP_IDLE;
        lcg_state       = 32'd29336;
        error_count     = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        for (int i = 0; i < DEPTH; i++) begin
            model[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_write_read();
        test_partial_masks();
        test_two_ways();
        test_dirty_eviction();
        test_random_mix();

        $display("Tests run: %0d, tests failed: %0d, check errors: %0d, assertion errors: %0d",
                 tests_run, tests_failed, error_count, uut.u_cache.u_checks.fail_count);
        if (error_count == 0 && uut.u_cache.u_checks.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
src/dcache_pkg.sv
src/data_memory.sv
src/data_cache.sv
src/dcache_top.sv
tests/dcache_assertions.sv
tests/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/dcache_pkg.sv
      - src/data_memory.sv
      - src/data_cache.sv
      - src/dcache_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - tests/dcache_assertions.sv
      - tests/dcache_tb.sv
